// File: rtl/exec_cfg.svh
// Bus widths for the execute stage, included by every RTL file that sizes a port
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data and address width
`define EXEC_XLEN 32

// Instruction tag width
`define EXEC_TAG_W 4

// Shift amount width, low bits of operand B
`define EXEC_SHAMT_W 5

`endif

// File: rtl/exec_pkg.sv
// Shared types of the execute stage, referenced by scoped name from the RTL and the testbench
`default_nettype none
`include "exec_cfg.svh"

package exec_pkg;

    // Functional unit that owns the operation
    typedef enum logic [2:0] {
        NONE    = 3'd0,         // Bubble, no unit selected
        ADDER   = 3'd1,         // Add, sub, set-less-than
        BITWISE = 3'd2,         // Logic and shifts
        BRANCH  = 3'd3,         // Branches and jumps
        MEMORY  = 3'd4,         // Loads and stores
        BYPASS  = 3'd5          // Operand B straight through (LUI)
    } xu_e;

    // Operation code, NOP must stay zero so reset gives NOP
    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,  SUB  = 5'd2,  SLT  = 5'd3,  SLTU = 5'd4,
        AND  = 5'd5,  OR   = 5'd6,  XOR  = 5'd7,
        SLL  = 5'd8,  SRL  = 5'd9,  SRA  = 5'd10,
        BEQ  = 5'd11, BNE  = 5'd12, BLT  = 5'd13, BGE  = 5'd14,
        BLTU = 5'd15, BGEU = 5'd16,
        JAL  = 5'd17, JALR = 5'd18,
        LB   = 5'd19, LH   = 5'd20, LW   = 5'd21, LBU  = 5'd22, LHU = 5'd23,
        SB   = 5'd24, SH   = 5'd25, SW   = 5'd26
    } op_e;

    // Word view of a byte address
    typedef struct packed {
        logic [`EXEC_XLEN-3:0] word;    // Word index
        logic [1:0]            offset;  // Byte within the word
    } mem_word_s;

    // Effective address, read as bytes or as word plus offset
    typedef union packed {
        logic [`EXEC_XLEN-1:0] byte_addr;   // Full byte address
        mem_word_s             word_addr;   // Word index and byte offset
    } mem_addr_u;

endpackage

`default_nettype wire

// File: rtl/adder_unit.sv
// Adder/compare unit of the execute stage, driven by execute_ctrl with NOP when idle
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module adder_unit (
    input  exec_pkg::op_e         op_i,   // Gated operation
    input  logic [`EXEC_XLEN-1:0] opa_i,  // Operand A
    input  logic [`EXEC_XLEN-1:0] opb_i,  // Operand B or immediate
    output logic [`EXEC_XLEN-1:0] res_o   // Sum, difference or 0/1 flag
);

    logic lt_signed;    // A < B as two's complement
    logic lt_unsigned;  // A < B as magnitudes

    assign lt_signed   = $signed(opa_i) < $signed(opb_i);
    assign lt_unsigned = opa_i < opb_i;

    always_comb begin
        case (op_i)
            exec_pkg::ADD:  res_o = opa_i + opb_i;
            exec_pkg::SUB:  res_o = opa_i - opb_i;
            exec_pkg::SLT:  res_o = `EXEC_XLEN'(lt_signed);     // Zero-extended flag
            exec_pkg::SLTU: res_o = `EXEC_XLEN'(lt_unsigned);
            default:        res_o = '0;                         // NOP and foreign ops
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/bitwise_unit.sv
// Logic and shift unit of the execute stage, driven by execute_ctrl with NOP when idle
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module bitwise_unit (
    input  exec_pkg::op_e         op_i,   // Gated operation
    input  logic [`EXEC_XLEN-1:0] opa_i,  // Operand A, value to shift
    input  logic [`EXEC_XLEN-1:0] opb_i,  // Operand B, shift amount in low bits
    output logic [`EXEC_XLEN-1:0] res_o   // Logic or shift result
);

    logic [`EXEC_SHAMT_W-1:0] shamt;      // Shift distance
    logic [`EXEC_XLEN-1:0]    sra_res;    // Sign-filled right shift

    assign shamt   = opb_i[`EXEC_SHAMT_W-1:0];   // Upper bits of B ignored
    assign sra_res = $unsigned($signed(opa_i) >>> shamt);

    always_comb begin
        case (op_i)
            ////////////////////////////////////////////////////////////
            // Logic
            exec_pkg::AND: res_o = opa_i & opb_i;
            exec_pkg::OR:  res_o = opa_i | opb_i;
            exec_pkg::XOR: res_o = opa_i ^ opb_i;

            ////////////////////////////////////////////////////////////
            // Shifts
            exec_pkg::SLL: res_o = opa_i << shamt;
            exec_pkg::SRL: res_o = opa_i >> shamt;   // Zero fill
            exec_pkg::SRA: res_o = sra_res;          // Sign kept

            default:       res_o = '0;               // NOP
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
// Branch/jump unit of the execute stage: evaluates the condition and builds target and link
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module branch_unit (
    input  exec_pkg::op_e         op_i,      // Gated operation
    input  logic [`EXEC_XLEN-1:0] opa_i,     // rs1 value
    input  logic [`EXEC_XLEN-1:0] opb_i,     // rs2 value
    input  logic [`EXEC_XLEN-1:0] opc_i,     // Branch or jump offset
    input  logic [`EXEC_XLEN-1:0] npc_i,     // Address of next instruction
    output logic [`EXEC_XLEN-1:0] target_o,  // Jump destination
    output logic [`EXEC_XLEN-1:0] link_o,    // Return address for JAL/JALR
    output logic                  taken_o    // Redirect fetch
);

    logic [`EXEC_XLEN-1:0] pc_rel;    // Offset from current pc
    logic [`EXEC_XLEN-1:0] reg_rel;   // JALR sum before bit 0 clear
    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;

    // Current pc is npc minus one instruction
    assign pc_rel  = npc_i - `EXEC_XLEN'(4) + opc_i;
    assign reg_rel = opa_i + opc_i;

    assign eq   = opa_i == opb_i;
    assign lt_s = $signed(opa_i) < $signed(opb_i);
    assign lt_u = opa_i < opb_i;

    always_comb begin
        target_o = pc_rel;   // Default for branches and JAL
        link_o   = '0;
        taken_o  = 1'b0;
        case (op_i)
            exec_pkg::BEQ:  taken_o = eq;
            exec_pkg::BNE:  taken_o = !eq;
            exec_pkg::BLT:  taken_o = lt_s;
            exec_pkg::BGE:  taken_o = !lt_s;
            exec_pkg::BLTU: taken_o = lt_u;
            exec_pkg::BGEU: taken_o = !lt_u;
            exec_pkg::JAL: begin
                taken_o = 1'b1;
                link_o  = npc_i;
            end
            exec_pkg::JALR: begin
                taken_o  = 1'b1;
                link_o   = npc_i;
                target_o = {reg_rel[`EXEC_XLEN-1:1], 1'b0};   // Bit 0 cleared
            end
            default: target_o = '0;   // NOP, quiet bus
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/load_store_unit.sv
// Load/store address unit: effective address, load strobe, store byte mask and lane data
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module load_store_unit (
    input  exec_pkg::op_e             op_i,     // Gated operation
    input  logic [`EXEC_XLEN-1:0]     opa_i,    // Base register
    input  logic [`EXEC_XLEN-1:0]     opb_i,    // Address offset
    input  logic [`EXEC_XLEN-1:0]     opc_i,    // Store data
    output logic [`EXEC_XLEN-1:0]     addr_o,   // Effective byte address
    output logic [`EXEC_XLEN-1:0]     data_o,   // Store data in its lane
    output logic [`EXEC_XLEN/8-1:0]   mask_o,   // Store byte enables
    output logic                      read_o,   // Load strobe
    output logic                      we_rf_o   // Load writes rd
);

    exec_pkg::mem_addr_u   ea;          // Effective address, two views
    logic [4:0]            lane_sh;     // Bit shift of the lane
    logic                  half_acc;    // LH, LHU or SH
    logic                  word_acc;    // LW or SW

    assign ea.byte_addr = opa_i + opb_i;
    assign addr_o       = ea.byte_addr;
    assign lane_sh      = {ea.word_addr.offset, 3'b000};   // Offset times 8

    assign half_acc = op_i inside {exec_pkg::LH, exec_pkg::LHU, exec_pkg::SH};
    assign word_acc = op_i inside {exec_pkg::LW, exec_pkg::SW};

    always_comb begin
        data_o  = '0;
        mask_o  = '0;
        read_o  = 1'b0;
        we_rf_o = 1'b0;
        case (op_i)
            exec_pkg::LB, exec_pkg::LH, exec_pkg::LW, exec_pkg::LBU, exec_pkg::LHU: begin
                read_o  = 1'b1;
                we_rf_o = 1'b1;
            end
            exec_pkg::SB: begin
                data_o = `EXEC_XLEN'(opc_i[7:0]) << lane_sh;
                mask_o = (`EXEC_XLEN/8)'(4'b0001) << ea.word_addr.offset;
            end
            exec_pkg::SH: begin
                data_o = `EXEC_XLEN'(opc_i[15:0]) << lane_sh;
                mask_o = (`EXEC_XLEN/8)'(4'b0011) << ea.word_addr.offset;
            end
            exec_pkg::SW: begin
                data_o = opc_i;                    // Offset is 0
                mask_o = (`EXEC_XLEN/8)'(4'b1111);
            end
            default: ;   // NOP
        endcase
    end

    // Misaligned accesses are outside this stage
    always_comb begin
        if (half_acc) begin
            assert final (ea.word_addr.offset[0] == 1'b0)
                else $error("Misaligned half-word access at %h", ea.byte_addr);
        end
        if (word_acc) begin
            assert final (ea.word_addr.offset == 2'b00)
                else $error("Misaligned word access at %h", ea.byte_addr);
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_ctrl.sv
// Execute stage control: gates the operation to one unit and registers that unit's results
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module execute_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  exec_pkg::xu_e             xu_i,            // Owning unit, NONE is a bubble
    input  exec_pkg::op_e             op_i,            // Operation from operand fetch
    input  logic [`EXEC_TAG_W-1:0]    tag_i,           // Instruction tag
    input  logic [`EXEC_XLEN-1:0]     opb_i,           // Bypass value
    // Unit results
    input  logic [`EXEC_XLEN-1:0]     add_res_i,
    input  logic [`EXEC_XLEN-1:0]     bit_res_i,
    input  logic [`EXEC_XLEN-1:0]     br_target_i,
    input  logic [`EXEC_XLEN-1:0]     br_link_i,
    input  logic                      br_taken_i,
    input  logic [`EXEC_XLEN-1:0]     ls_addr_i,
    input  logic [`EXEC_XLEN-1:0]     ls_data_i,
    input  logic [`EXEC_XLEN/8-1:0]   ls_mask_i,
    input  logic                      ls_read_i,
    input  logic                      ls_we_rf_i,
    // Gated operations, NOP to idle units
    output exec_pkg::op_e             add_op_o,
    output exec_pkg::op_e             bit_op_o,
    output exec_pkg::op_e             br_op_o,
    output exec_pkg::op_e             ls_op_o,
    // Registered stage outputs
    output logic [`EXEC_XLEN-1:0]     result0_o,       // Result, link or store data
    output logic [`EXEC_XLEN-1:0]     result1_o,       // Target or store address
    output logic                      jump_o,          // Branch taken
    output logic                      we_rf_o,         // Register write enable
    output logic                      mem_access_o,    // Any memory op
    output logic [`EXEC_XLEN/8-1:0]   we_mem_o,        // Store byte mask
    output logic                      read_o,          // Load strobe
    output logic [`EXEC_XLEN-1:0]     read_address_o,  // Load address
    output exec_pkg::op_e             op_o,
    output logic [`EXEC_TAG_W-1:0]    tag_o
);

    logic [`EXEC_XLEN-1:0]   result0_d;
    logic [`EXEC_XLEN-1:0]   result1_d;
    logic                    jump_d;
    logic                    we_rf_d;
    logic                    mem_access_d;
    logic [`EXEC_XLEN/8-1:0] we_mem_d;
    logic                    read_d;
    logic [`EXEC_XLEN-1:0]   read_address_d;

    ////////////////////////////////////////////////////////////
    // Dispatch
    assign add_op_o = (xu_i == exec_pkg::ADDER)   ? op_i : exec_pkg::NOP;
    assign bit_op_o = (xu_i == exec_pkg::BITWISE) ? op_i : exec_pkg::NOP;
    assign br_op_o  = (xu_i == exec_pkg::BRANCH)  ? op_i : exec_pkg::NOP;
    assign ls_op_o  = (xu_i == exec_pkg::MEMORY)  ? op_i : exec_pkg::NOP;

    ////////////////////////////////////////////////////////////
    // Result select
    always_comb begin
        result0_d      = '0;   // Bubble defaults
        result1_d      = '0;
        jump_d         = 1'b0;
        we_rf_d        = 1'b0;
        mem_access_d   = 1'b0;
        we_mem_d       = '0;
        read_d         = 1'b0;
        read_address_d = '0;
        case (xu_i)
            exec_pkg::ADDER: begin
                result0_d = add_res_i;
                we_rf_d   = 1'b1;
            end
            exec_pkg::BITWISE: begin
                result0_d = bit_res_i;
                we_rf_d   = 1'b1;
            end
            exec_pkg::BRANCH: begin
                result0_d = br_link_i;                              // Zero for plain branches
                result1_d = br_target_i;
                jump_d    = br_taken_i;
                we_rf_d   = op_i inside {exec_pkg::JAL, exec_pkg::JALR};   // Only jumps link
            end
            exec_pkg::MEMORY: begin
                result0_d      = ls_data_i;
                result1_d      = ls_addr_i;
                we_rf_d        = ls_we_rf_i;
                mem_access_d   = 1'b1;
                we_mem_d       = ls_mask_i;
                read_d         = ls_read_i;
                read_address_d = ls_read_i ? ls_addr_i : '0;
            end
            exec_pkg::BYPASS: begin
                result0_d = opb_i;   // LUI style immediate
                we_rf_d   = 1'b1;
            end
            default: ;   // NONE
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result0_o      <= '0;
            result1_o      <= '0;
            jump_o         <= 1'b0;
            we_rf_o        <= 1'b0;
            mem_access_o   <= 1'b0;
            we_mem_o       <= '0;
            read_o         <= 1'b0;
            read_address_o <= '0;
            op_o           <= exec_pkg::NOP;
            tag_o          <= '0;
        end else begin
            result0_o      <= result0_d;
            result1_o      <= result1_d;
            jump_o         <= jump_d;
            we_rf_o        <= we_rf_d;
            mem_access_o   <= mem_access_d;
            we_mem_o       <= we_mem_d;
            read_o         <= read_d;
            read_address_o <= read_address_d;
            op_o           <= op_i;
            tag_o          <= tag_i;
        end
    end

    // Taken flag only follows a cycle owned by the branch unit
    a_jump_from_branch : assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(jump_o) |-> $past(xu_i) == exec_pkg::BRANCH);

    // A load and a store never leave in the same cycle
    a_read_xor_write : assert property (@(posedge clk) disable iff (!arst_n_i)
        !(read_o && (we_mem_o != '0)));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage top: control plus the four functional units, one register stage deep
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module execute_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`EXEC_XLEN-1:0]     npc_i,           // Next instruction address
    input  logic [`EXEC_XLEN-1:0]     opa_i,
    input  logic [`EXEC_XLEN-1:0]     opb_i,
    input  logic [`EXEC_XLEN-1:0]     opc_i,           // Branch offset or store data
    input  exec_pkg::op_e             op_i,
    input  exec_pkg::xu_e             xu_i,
    input  logic [`EXEC_TAG_W-1:0]    tag_i,
    output logic [`EXEC_XLEN-1:0]     result0_o,
    output logic [`EXEC_XLEN-1:0]     result1_o,
    output logic                      jump_o,
    output logic                      we_rf_o,
    output logic                      mem_access_o,
    output logic [`EXEC_XLEN/8-1:0]   we_mem_o,
    output logic                      read_o,
    output logic [`EXEC_XLEN-1:0]     read_address_o,
    output exec_pkg::op_e             op_o,
    output logic [`EXEC_TAG_W-1:0]    tag_o
);

    exec_pkg::op_e           add_op;      // Gated ops
    exec_pkg::op_e           bit_op;
    exec_pkg::op_e           br_op;
    exec_pkg::op_e           ls_op;
    logic [`EXEC_XLEN-1:0]   add_res;     // Unit results
    logic [`EXEC_XLEN-1:0]   bit_res;
    logic [`EXEC_XLEN-1:0]   br_target;
    logic [`EXEC_XLEN-1:0]   br_link;
    logic                    br_taken;
    logic [`EXEC_XLEN-1:0]   ls_addr;
    logic [`EXEC_XLEN-1:0]   ls_data;
    logic [`EXEC_XLEN/8-1:0] ls_mask;
    logic                    ls_read;
    logic                    ls_we_rf;

    execute_ctrl u_ctrl (
        .clk(clk), .arst_n_i(arst_n_i), .xu_i(xu_i), .op_i(op_i), .tag_i(tag_i),
        .opb_i(opb_i), .add_res_i(add_res), .bit_res_i(bit_res),
        .br_target_i(br_target), .br_link_i(br_link), .br_taken_i(br_taken),
        .ls_addr_i(ls_addr), .ls_data_i(ls_data), .ls_mask_i(ls_mask),
        .ls_read_i(ls_read), .ls_we_rf_i(ls_we_rf),
        .add_op_o(add_op), .bit_op_o(bit_op), .br_op_o(br_op), .ls_op_o(ls_op),
        .result0_o(result0_o), .result1_o(result1_o), .jump_o(jump_o),
        .we_rf_o(we_rf_o), .mem_access_o(mem_access_o), .we_mem_o(we_mem_o),
        .read_o(read_o), .read_address_o(read_address_o), .op_o(op_o), .tag_o(tag_o)
    );

    adder_unit u_adder (
        .op_i(add_op), .opa_i(opa_i), .opb_i(opb_i), .res_o(add_res)
    );

    bitwise_unit u_bitwise (
        .op_i(bit_op), .opa_i(opa_i), .opb_i(opb_i), .res_o(bit_res)
    );

    branch_unit u_branch (
        .op_i(br_op), .opa_i(opa_i), .opb_i(opb_i), .opc_i(opc_i), .npc_i(npc_i),
        .target_o(br_target), .link_o(br_link), .taken_o(br_taken)
    );

    load_store_unit u_lsu (
        .op_i(ls_op), .opa_i(opa_i), .opb_i(opb_i), .opc_i(opc_i),
        .addr_o(ls_addr), .data_o(ls_data), .mask_o(ls_mask),
        .read_o(ls_read), .we_rf_o(ls_we_rf)
    );

endmodule

`default_nettype wire

// File: verification/exec_checker.sv
// Testbench checker: reads the expected outputs from the trace and compares them one cycle later
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_checker (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    valid_i,         // A trace line was driven this cycle
    input  logic [`EXEC_XLEN-1:0]   result0_i,
    input  logic [`EXEC_XLEN-1:0]   result1_i,
    input  logic                    jump_i,
    input  logic                    we_rf_i,
    input  logic                    mem_access_i,
    input  logic [`EXEC_XLEN/8-1:0] we_mem_i,
    input  logic                    read_i,
    input  logic [`EXEC_XLEN-1:0]   read_address_i,
    input  exec_pkg::op_e           op_i,
    input  logic [`EXEC_TAG_W-1:0]  tag_i,
    output logic                    done_o,          // Last line compared
    output int                      fail_cnt_o       // Failed tests
);

    int                    fd;            // Trace handle
    int                    pass_cnt;
    logic                  pend;          // Line from previous cycle awaits compare
    logic                  line_bad;      // Mismatch in current test
    string                 t_name;
    logic [31:0]           f_xu, f_op, f_tag, f_npc, f_opa, f_opb, f_opc;
    logic [31:0]           e_r0, e_jump, e_we_rf, e_mem, e_we_mem, e_read;
    exec_pkg::mem_addr_u   e_r1;          // Target or store address
    exec_pkg::mem_addr_u   e_raddr;       // Load address

    // Next non-comment line of the trace
    task automatic next_line(output bit found);
        string line;
        int    n;
        found = 0;
        while (!found && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            t_name, f_xu, f_op, f_tag, f_npc, f_opa, f_opb, f_opc,
                            e_r0, e_r1, e_jump, e_we_rf, e_mem, e_we_mem, e_read, e_raddr);
                found = (n == 16);
            end
        end
    endtask

    task automatic compare(input string name, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %h, actual %h", name, field, exp, act);
            line_bad = 1'b1;
        end
    endtask

    task automatic close_test(input string name);
        if (line_bad) begin
            fail_cnt_o = fail_cnt_o + 1;
        end else begin
            pass_cnt = pass_cnt + 1;
            $display("[PASS] %s", name);
        end
    endtask

    initial begin
        fd         = $fopen("verification/exec_trace.txt", "r");
        pass_cnt   = 0;
        fail_cnt_o = 0;
        done_o     = 1'b0;
        pend       = 1'b0;
        if (fd == 0) begin
            $display("Checker could not open the trace file");
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset state, before the first line lands
    initial begin
        @(posedge arst_n_i);
        @(negedge clk);
        line_bad = 1'b0;
        compare("reset", "result0", '0, result0_i);
        compare("reset", "result1", '0, result1_i);
        compare("reset", "jump", 0, 32'(jump_i));
        compare("reset", "we_rf", 0, 32'(we_rf_i));
        compare("reset", "mem_access", 0, 32'(mem_access_i));
        compare("reset", "we_mem", 0, 32'(we_mem_i));
        compare("reset", "read", 0, 32'(read_i));
        compare("reset", "read_address", '0, read_address_i);
        compare("reset", "op", 32'(exec_pkg::NOP), 32'(op_i));
        compare("reset", "tag", 0, 32'(tag_i));
        close_test("reset");
    end

    ////////////////////////////////////////////////////////////
    // Per-line compare, sampled mid-cycle where outputs are stable
    always @(negedge clk) begin
        bit found;
        if (pend && !done_o) begin
            next_line(found);
            line_bad = 1'b0;
            if (!found) begin
                $display("Checker ran out of trace lines while the DUT was still driven");
                line_bad = 1'b1;
            end else begin
                compare(t_name, "result0", e_r0, result0_i);
                compare(t_name, "result1", e_r1.byte_addr, result1_i);
                compare(t_name, "jump", e_jump, 32'(jump_i));
                compare(t_name, "we_rf", e_we_rf, 32'(we_rf_i));
                compare(t_name, "mem_access", e_mem, 32'(mem_access_i));
                compare(t_name, "we_mem", e_we_mem, 32'(we_mem_i));
                compare(t_name, "read", e_read, 32'(read_i));
                compare(t_name, "read_address", e_raddr.byte_addr, read_address_i);
                compare(t_name, "op", f_op, 32'(op_i));
                compare(t_name, "tag", f_tag, 32'(tag_i));
            end
            close_test(t_name);
            if (!valid_i) begin
                $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt_o);
                done_o = 1'b1;
            end
        end
        pend = valid_i;
    end

endmodule

`default_nettype wire

// File: verification/exec_tb.sv
// Testbench top for the execute stage: clock, reset, trace driven stimulus and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_tb;

    localparam int CLK_PERIOD = 8;
    localparam string TRACE   = "verification/exec_trace.txt";

    logic                    clk;
    logic                    arst_n_i;
    logic                    valid;          // Line on the inputs this cycle
    logic [`EXEC_XLEN-1:0]   npc_i, opa_i, opb_i, opc_i;
    exec_pkg::op_e           op_i;
    exec_pkg::xu_e           xu_i;
    logic [`EXEC_TAG_W-1:0]  tag_i;
    logic [`EXEC_XLEN-1:0]   result0_o, result1_o, read_address_o;
    logic                    jump_o, we_rf_o, mem_access_o, read_o;
    logic [`EXEC_XLEN/8-1:0] we_mem_o;
    exec_pkg::op_e           op_o;
    logic [`EXEC_TAG_W-1:0]  tag_o;
    logic                    done;
    int                      fail_cnt;
    int                      fd;
    int                      n_lines;        // Sizes the watchdog
    logic                    lines_counted;  // Line count is final
    logic [31:0]             f_xu, f_op, f_tag, f_npc, f_opa, f_opb, f_opc;

    execute_stage u_dut (
        .clk(clk), .arst_n_i(arst_n_i), .npc_i(npc_i), .opa_i(opa_i), .opb_i(opb_i),
        .opc_i(opc_i), .op_i(op_i), .xu_i(xu_i), .tag_i(tag_i),
        .result0_o(result0_o), .result1_o(result1_o), .jump_o(jump_o),
        .we_rf_o(we_rf_o), .mem_access_o(mem_access_o), .we_mem_o(we_mem_o),
        .read_o(read_o), .read_address_o(read_address_o), .op_o(op_o), .tag_o(tag_o)
    );

    exec_checker u_checker (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid),
        .result0_i(result0_o), .result1_i(result1_o), .jump_i(jump_o),
        .we_rf_i(we_rf_o), .mem_access_i(mem_access_o), .we_mem_i(we_mem_o),
        .read_i(read_o), .read_address_i(read_address_o), .op_i(op_o), .tag_i(tag_o),
        .done_o(done), .fail_cnt_o(fail_cnt)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Stimulus fields of the next non-comment line
    task automatic fetch_stimulus(output bit found);
        string line;
        string name;
        int    n;
        found = 0;
        while (!found && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                            name, f_xu, f_op, f_tag, f_npc, f_opa, f_opb, f_opc);
                found = (n == 8);
            end
        end
    endtask

    initial begin
        bit found;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        valid         = 1'b0;
        npc_i         = '0;
        opa_i         = '0;
        opb_i         = '0;
        opc_i         = '0;
        op_i          = exec_pkg::NOP;
        xu_i          = exec_pkg::NONE;
        tag_i         = '0;
        n_lines       = 0;
        lines_counted = 1'b0;
        fd = $fopen(TRACE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            $display("Errors found");
            $finish;
        end else begin
            found = 1;
            while (found) begin   // Count lines first
                fetch_stimulus(found);
                if (found) n_lines = n_lines + 1;
            end
            lines_counted = 1'b1;
            $fclose(fd);
            fd = $fopen(TRACE, "r");
            repeat (4) @(posedge clk);
            arst_n_i <= 1'b1;
            repeat (2) @(posedge clk);
            fetch_stimulus(found);
            while (found) begin
                xu_i  <= exec_pkg::xu_e'(f_xu[2:0]);
                op_i  <= exec_pkg::op_e'(f_op[4:0]);
                tag_i <= f_tag[`EXEC_TAG_W-1:0];
                npc_i <= f_npc;
                opa_i <= f_opa;
                opb_i <= f_opb;
                opc_i <= f_opc;
                valid <= 1'b1;
                @(posedge clk);
                fetch_stimulus(found);
            end
            xu_i  <= exec_pkg::NONE;   // Back to bubbles
            op_i  <= exec_pkg::NOP;
            valid <= 1'b0;
            wait (done);
            if (fail_cnt == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Watchdog, one cycle per line plus 20 cycles of margin
    initial begin
        wait (lines_counted);
        #(n_lines * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("Timeout: the checker did not finish the trace in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/adder_unit.sv
rtl/bitwise_unit.sv
rtl/branch_unit.sv
rtl/load_store_unit.sv
rtl/execute_ctrl.sv
rtl/execute_stage.sv
verification/exec_checker.sv
verification/exec_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
FILE_LIST ?= files.f
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))
HDRS := rtl/exec_cfg.svh
BIN  := $(SIM_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

run: $(BIN) verification/exec_trace.txt
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^No errors$$' $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// File: verification/exec_trace.txt
# name xu op tag npc opa opb opc | expected: result0 result1 jump we_rf mem_access we_mem read read_address
# All values hex; xu and op are the numeric exec_pkg codes; op_o and tag_o expect the driven op and tag
bubble_start 0 00 0 00000000 00000000 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000
add          1 01 1 00000000 00000005 00000007 00000000 0000000c 00000000 0 1 0 0 0 00000000
sub          1 02 2 00000000 00000005 00000007 00000000 fffffffe 00000000 0 1 0 0 0 00000000
slt_signed   1 03 3 00000000 ffffffff 00000001 00000000 00000001 00000000 0 1 0 0 0 00000000
sltu         1 04 4 00000000 ffffffff 00000001 00000000 00000000 00000000 0 1 0 0 0 00000000
and          2 05 5 00000000 f0f0f0f0 ff00ff00 00000000 f000f000 00000000 0 1 0 0 0 00000000
or           2 06 6 00000000 f0f0f0f0 0f0f0000 00000000 fffff0f0 00000000 0 1 0 0 0 00000000
xor          2 07 7 00000000 aaaa5555 ffff0000 00000000 55555555 00000000 0 1 0 0 0 00000000
sll          2 08 8 00000000 00000001 00000024 00000000 00000010 00000000 0 1 0 0 0 00000000
srl          2 09 9 00000000 80000000 00000004 00000000 08000000 00000000 0 1 0 0 0 00000000
sra_neg      2 0a a 00000000 80000000 00000004 00000000 f8000000 00000000 0 1 0 0 0 00000000
bypass       5 00 b 00000000 00000000 12345000 00000000 12345000 00000000 0 1 0 0 0 00000000
beq_taken    3 0b c 00001004 00000007 00000007 00000010 00000000 00001010 1 0 0 0 0 00000000
bne_not      3 0c d 00001004 00000007 00000007 00000010 00000000 00001010 0 0 0 0 0 00000000
blt_taken    3 0d e 00002000 ffffffff 00000001 fffffff0 00000000 00001fec 1 0 0 0 0 00000000
bltu_not     3 0f f 00002000 ffffffff 00000001 fffffff0 00000000 00001fec 0 0 0 0 0 00000000
bge_taken    3 0e 0 00003000 00000005 fffffffb 00000008 00000000 00003004 1 0 0 0 0 00000000
bgeu_not     3 10 1 00003000 00000005 fffffffb 00000008 00000000 00003004 0 0 0 0 0 00000000
jal          3 11 2 00004004 00000000 00000000 00000100 00004004 00004100 1 1 0 0 0 00000000
jalr         3 12 3 00005008 00006001 00000000 00000004 00005008 00006004 1 1 0 0 0 00000000
lw           4 15 4 00000000 00001000 00000008 00000000 00000000 00001008 0 1 1 0 1 00001008
lb_odd       4 13 5 00000000 00001000 00000003 00000000 00000000 00001003 0 1 1 0 1 00001003
lhu          4 17 6 00000000 00001000 00000002 00000000 00000000 00001002 0 1 1 0 1 00001002
sb_off0      4 18 7 00000000 00002000 00000000 000000a5 000000a5 00002000 0 0 1 1 0 00000000
sb_off1      4 18 8 00000000 00002000 00000001 000000a5 0000a500 00002001 0 0 1 2 0 00000000
sb_off2      4 18 9 00000000 00002000 00000002 000000a5 00a50000 00002002 0 0 1 4 0 00000000
sb_off3      4 18 a 00000000 00002000 00000003 000000a5 a5000000 00002003 0 0 1 8 0 00000000
sh_off0      4 19 b 00000000 00002000 00000000 1234beef 0000beef 00002000 0 0 1 3 0 00000000
sh_off2      4 19 c 00000000 00002000 00000002 1234beef beef0000 00002002 0 0 1 c 0 00000000
sw           4 1a d 00000000 00002000 00000004 cafef00d cafef00d 00002004 0 0 1 f 0 00000000
bubble_end   0 00 e 00000000 00000000 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000
